/* mmu_macros.svh */
`ifndef MMU_MACROS_SVH
`define MMU_MACROS_SVH

// Architectural widths for Sv32
`define XLEN 32
`define VALEN 32

// Sv32 physical addresses are 34 bits wide
`define PALEN 34

// Entries per TLB
`define TLB_DEPTH 4

// One TLB per port
// Port 0 serves instruction fetch and port 1 serves load/store
`define TLB_PORTS 2

`endif

/* mmu_pkg.sv */
`include "mmu_macros.svh"

package mmu_pkg;

    // Sv32 page table entry, ppn on top
    typedef struct packed {
        logic [21:0] ppn;
        logic [1:0]  rsw;
        logic        d;
        logic        a;
        logic        g;
        logic        u;
        logic        x;
        logic        w;
        logic        r;
        logic        v;
    } pte_sv32_s;

    typedef enum logic [1:0] {
        PTW_IDLE,
        PTW_PROCESS_PTE,
        PTW_PAGE_ERR,
        PTW_WAIT_R_VALID
    } ptw_state_e;

    typedef enum logic {
        LEVEL_1,
        LEVEL_2
    } ptw_level_e;

    typedef struct packed {
        logic        valid;
        logic [19:0] vpn;
        logic        page_4m;
        pte_sv32_s   pte;
    } tlb_entry_s;

    typedef struct packed {
        logic        hit;
        pte_sv32_s   pte;
        logic        page_4m;
    } tlb_lookup_s;

    // Miss request from the translation stage to the walker
    typedef struct packed {
        logic              imiss;
        logic              dmiss;
        logic [`VALEN-1:0] ivaddr;
        logic [`VALEN-1:0] dvaddr;
        logic              is_store;
        logic              mxr;
        logic [21:0]       satp_ppn;
        logic              flush;
    } mmu2ptw_s;

    typedef struct packed {
        logic ptw_active;
        logic iwalk_active;
        logic pte_error;
    } ptw2mmu_s;

    typedef struct packed {
        logic [19:0] vpn;
        logic        page_4m;
        pte_sv32_s   pte;
    } ptw2tlb_s;

endpackage

/* mem_pkg.sv */
`include "mmu_macros.svh"

package mem_pkg;

    // Read strobe with its PTE address
    typedef struct packed {
        logic              r_req;
        logic [`PALEN-1:0] paddr;
    } mmu2dmem_s;

    // Single cycle read response
    typedef struct packed {
        logic             r_valid;
        logic [`XLEN-1:0] r_data;
    } dmem2mmu_s;

endpackage

/* ptw.sv */
`timescale 1ns/1ns
`include "mmu_macros.svh"

module ptw (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mmu_pkg::mmu2ptw_s      mmu2ptw_i,
    output mmu_pkg::ptw2mmu_s      ptw2mmu_o,
    output mmu_pkg::ptw2tlb_s      ptw2tlb_o,
    output logic [`TLB_PORTS-1:0]  tlb_update_o,
    output mem_pkg::mmu2dmem_s     ptw2dmem_o,
    input  mem_pkg::dmem2mmu_s     dmem2ptw_i
);

    mmu_pkg::ptw_state_e ptw_state_ff, ptw_state_next;
    mmu_pkg::ptw_level_e ptw_lvl_ff, ptw_lvl_next;
    mmu_pkg::pte_sv32_s  pte;
    mmu_pkg::pte_sv32_s  leaf_pte;

    // Registered memory response
    logic [`XLEN-1:0]  r_data_ff;
    logic              r_data_valid_ff;

    // Walk context
    logic              iwalk_active_ff, iwalk_active_next;
    logic              gmap_bit_ff, gmap_bit_next;
    logic [`VALEN-1:0] vaddr_ff, vaddr_next;

    // Memory read strobe and address
    logic [`PALEN-1:0] ptw_paddr_ff, ptw_paddr_next;
    logic              r_req_ff, r_req_next;

    logic              itlb_update;
    logic              dtlb_update;
    logic              pte_error;

    assign pte = mmu_pkg::pte_sv32_s'(r_data_ff);

    // Global mapping from the pointer level carries into the leaf
    always_comb begin
        leaf_pte   = pte;
        leaf_pte.g = pte.g | gmap_bit_ff;
    end

    always_comb begin : ptw_walker
        ptw_state_next    = ptw_state_ff;
        ptw_lvl_next      = ptw_lvl_ff;
        ptw_paddr_next    = ptw_paddr_ff;
        vaddr_next        = vaddr_ff;
        iwalk_active_next = iwalk_active_ff;
        gmap_bit_next     = gmap_bit_ff;
        r_req_next        = 1'b0;
        itlb_update       = 1'b0;
        dtlb_update       = 1'b0;
        pte_error         = 1'b0;

        case (ptw_state_ff)
            mmu_pkg::PTW_IDLE: begin
                ptw_lvl_next  = mmu_pkg::LEVEL_1;
                gmap_bit_next = 1'b0;
                // Instruction side wins when both miss
                if (mmu2ptw_i.imiss) begin
                    ptw_paddr_next    = {mmu2ptw_i.satp_ppn, mmu2ptw_i.ivaddr[31:22], 2'b00};
                    vaddr_next        = mmu2ptw_i.ivaddr;
                    iwalk_active_next = 1'b1;
                    r_req_next        = 1'b1;
                    ptw_state_next    = mmu_pkg::PTW_PROCESS_PTE;
                end else if (mmu2ptw_i.dmiss) begin
                    ptw_paddr_next    = {mmu2ptw_i.satp_ppn, mmu2ptw_i.dvaddr[31:22], 2'b00};
                    vaddr_next        = mmu2ptw_i.dvaddr;
                    iwalk_active_next = 1'b0;
                    r_req_next        = 1'b1;
                    ptw_state_next    = mmu_pkg::PTW_PROCESS_PTE;
                end
            end

            mmu_pkg::PTW_PROCESS_PTE: begin
                if (r_data_valid_ff) begin
                    gmap_bit_next = pte.g;
                    if (!pte.v || (!pte.r && pte.w)) begin
                        ptw_state_next = mmu_pkg::PTW_PAGE_ERR;
                    end else if (pte.r || pte.x) begin
                        // Leaf PTE
                        ptw_state_next = mmu_pkg::PTW_IDLE;
                        if (iwalk_active_ff) begin
                            if (!pte.x || !pte.a)
                                ptw_state_next = mmu_pkg::PTW_PAGE_ERR;
                            else
                                itlb_update = 1'b1;
                        end else begin
                            // MXR makes executable pages readable
                            if (pte.a && (pte.r || (pte.x && mmu2ptw_i.mxr)))
                                dtlb_update = 1'b1;
                            else
                                ptw_state_next = mmu_pkg::PTW_PAGE_ERR;
                            if (mmu2ptw_i.is_store && (!pte.w || !pte.d)) begin
                                dtlb_update    = 1'b0;
                                ptw_state_next = mmu_pkg::PTW_PAGE_ERR;
                            end
                        end
                        // Superpage needs PPN[0] cleared
                        if ((ptw_lvl_ff == mmu_pkg::LEVEL_1) && (pte.ppn[9:0] != '0)) begin
                            itlb_update    = 1'b0;
                            dtlb_update    = 1'b0;
                            ptw_state_next = mmu_pkg::PTW_PAGE_ERR;
                        end
                    end else if (ptw_lvl_ff == mmu_pkg::LEVEL_1) begin
                        // Pointer to the second level table
                        ptw_lvl_next   = mmu_pkg::LEVEL_2;
                        ptw_paddr_next = {pte.ppn, vaddr_ff[21:12], 2'b00};
                        r_req_next     = 1'b1;
                    end else begin
                        // No pointer allowed at the last level
                        ptw_state_next = mmu_pkg::PTW_PAGE_ERR;
                    end
                end
            end

            mmu_pkg::PTW_PAGE_ERR: begin
                pte_error      = 1'b1;
                ptw_state_next = mmu_pkg::PTW_IDLE;
            end

            mmu_pkg::PTW_WAIT_R_VALID: begin
                if (r_data_valid_ff)
                    ptw_state_next = mmu_pkg::PTW_IDLE;
            end

            default: begin
                ptw_state_next = mmu_pkg::PTW_IDLE;
            end
        endcase

        // Flush drops the walk but still absorbs a pending read
        if (mmu2ptw_i.flush) begin
            itlb_update = 1'b0;
            dtlb_update = 1'b0;
            r_req_next  = 1'b0;
            if (((ptw_state_ff == mmu_pkg::PTW_PROCESS_PTE) ||
                 (ptw_state_ff == mmu_pkg::PTW_WAIT_R_VALID)) && !r_data_valid_ff)
                ptw_state_next = mmu_pkg::PTW_WAIT_R_VALID;
            else
                ptw_state_next = mmu_pkg::PTW_IDLE;
        end
    end : ptw_walker

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptw_state_ff    <= mmu_pkg::PTW_IDLE;
            ptw_lvl_ff      <= mmu_pkg::LEVEL_1;
            iwalk_active_ff <= 1'b0;
            gmap_bit_ff     <= 1'b0;
            r_req_ff        <= 1'b0;
            r_data_valid_ff <= 1'b0;
        end else begin
            ptw_state_ff    <= ptw_state_next;
            ptw_lvl_ff      <= ptw_lvl_next;
            iwalk_active_ff <= iwalk_active_next;
            gmap_bit_ff     <= gmap_bit_next;
            r_req_ff        <= r_req_next;
            r_data_valid_ff <= dmem2ptw_i.r_valid;
        end
    end

    always_ff @(posedge clk) begin
        ptw_paddr_ff <= ptw_paddr_next;
        vaddr_ff     <= vaddr_next;
        r_data_ff    <= dmem2ptw_i.r_data;
    end

    // Update bit goes to the side that missed
    always_comb begin
        tlb_update_o    = '0;
        tlb_update_o[0] = itlb_update;
        tlb_update_o[1] = dtlb_update;
    end

    assign ptw2tlb_o.vpn     = vaddr_ff[31:12];
    assign ptw2tlb_o.page_4m = (ptw_lvl_ff == mmu_pkg::LEVEL_1);
    assign ptw2tlb_o.pte     = leaf_pte;

    assign ptw2mmu_o.ptw_active   = (ptw_state_ff != mmu_pkg::PTW_IDLE);
    assign ptw2mmu_o.iwalk_active = iwalk_active_ff;
    assign ptw2mmu_o.pte_error    = pte_error;

    assign ptw2dmem_o.r_req = r_req_ff;
    assign ptw2dmem_o.paddr = ptw_paddr_ff;

endmodule

/* tlb.sv */
`timescale 1ns/1ns
`include "mmu_macros.svh"

module tlb (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [19:0]           lookup_vpn_i,
    input  logic                  update_i,
    input  mmu_pkg::ptw2tlb_s     ptw2tlb_i,
    input  logic                  flush_i,
    output mmu_pkg::tlb_lookup_s  lookup_o
);

    localparam int PTR_W = $clog2(`TLB_DEPTH);

    mmu_pkg::tlb_entry_s   entries [`TLB_DEPTH];
    mmu_pkg::tlb_entry_s   new_entry;
    logic [PTR_W-1:0]      victim_ptr;
    logic [`TLB_DEPTH-1:0] match;

    // Superpage entries only compare VPN[1]
    always_comb begin
        for (int i = 0; i < `TLB_DEPTH; i++) begin
            if (entries[i].page_4m)
                match[i] = entries[i].valid &&
                           (entries[i].vpn[19:10] == lookup_vpn_i[19:10]);
            else
                match[i] = entries[i].valid && (entries[i].vpn == lookup_vpn_i);
        end
    end

    // Lowest matching entry wins
    always_comb begin
        lookup_o = '0;
        for (int i = 0; i < `TLB_DEPTH; i++) begin
            if (match[i] && !lookup_o.hit) begin
                lookup_o.hit     = 1'b1;
                lookup_o.pte     = entries[i].pte;
                lookup_o.page_4m = entries[i].page_4m;
            end
        end
    end

    always_comb begin
        new_entry.valid   = 1'b1;
        new_entry.vpn     = ptw2tlb_i.vpn;
        new_entry.page_4m = ptw2tlb_i.page_4m;
        new_entry.pte     = ptw2tlb_i.pte;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            victim_ptr <= '0;
            for (int i = 0; i < `TLB_DEPTH; i++)
                entries[i].valid <= 1'b0;
        end else begin
            if (update_i) begin
                entries[victim_ptr] <= new_entry;
                victim_ptr          <= victim_ptr + 1'b1;
            end
            // Flush after the update so a flush always leaves the TLB empty
            if (flush_i) begin
                for (int i = 0; i < `TLB_DEPTH; i++)
                    entries[i].valid <= 1'b0;
            end
        end
    end

endmodule

/* mmu_xlate.sv */
`timescale 1ns/1ns
`include "mmu_macros.svh"

module mmu_xlate (
    input  logic                                        ireq_i,
    input  logic [`VALEN-1:0]                           ivaddr_i,
    input  logic                                        dreq_i,
    input  logic [`VALEN-1:0]                           dvaddr_i,
    input  logic                                        is_store_i,
    input  logic                                        mxr_i,
    input  logic [21:0]                                 satp_ppn_i,
    input  logic                                        flush_i,
    input  mmu_pkg::tlb_lookup_s [`TLB_PORTS-1:0]       lookup_i,
    input  mmu_pkg::ptw2mmu_s                           ptw2mmu_i,
    output mmu_pkg::mmu2ptw_s                           mmu2ptw_o,
    output logic                                        ivalid_o,
    output logic [`PALEN-1:0]                           ipaddr_o,
    output logic                                        dvalid_o,
    output logic [`PALEN-1:0]                           dpaddr_o,
    output logic                                        ifault_o,
    output logic                                        dfault_o
);

    // Superpages take VPN[0] from the virtual address
    function automatic logic [`PALEN-1:0] form_paddr(
        input mmu_pkg::tlb_lookup_s lk,
        input logic [`VALEN-1:0]    vaddr
    );
        if (lk.page_4m)
            return {lk.pte.ppn[21:10], vaddr[21:0]};
        else
            return {lk.pte.ppn, vaddr[11:0]};
    endfunction

    // Port 0 is fetch, port 1 is load/store
    assign ivalid_o = ireq_i & lookup_i[0].hit;
    assign dvalid_o = dreq_i & lookup_i[1].hit;
    assign ipaddr_o = form_paddr(lookup_i[0], ivaddr_i);
    assign dpaddr_o = form_paddr(lookup_i[1], dvaddr_i);

    // Data miss waits while a fetch request is pending
    assign mmu2ptw_o.imiss    = ireq_i & ~lookup_i[0].hit;
    assign mmu2ptw_o.dmiss    = dreq_i & ~lookup_i[1].hit & ~ireq_i;
    assign mmu2ptw_o.ivaddr   = ivaddr_i;
    assign mmu2ptw_o.dvaddr   = dvaddr_i;
    assign mmu2ptw_o.is_store = is_store_i;
    assign mmu2ptw_o.mxr      = mxr_i;
    assign mmu2ptw_o.satp_ppn = satp_ppn_i;
    assign mmu2ptw_o.flush    = flush_i;

    // Walker error goes to the side that started the walk
    assign ifault_o = ptw2mmu_i.pte_error & ptw2mmu_i.iwalk_active;
    assign dfault_o = ptw2mmu_i.pte_error & ~ptw2mmu_i.iwalk_active;

endmodule

/* mmu_top.sv */
`timescale 1ns/1ns
`include "mmu_macros.svh"

module mmu_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ireq_i,
    input  logic [`VALEN-1:0]   ivaddr_i,
    input  logic                dreq_i,
    input  logic [`VALEN-1:0]   dvaddr_i,
    input  logic                is_store_i,
    input  logic                mxr_i,
    input  logic [21:0]         satp_ppn_i,
    input  logic                flush_i,
    output logic                ivalid_o,
    output logic [`PALEN-1:0]   ipaddr_o,
    output logic                dvalid_o,
    output logic [`PALEN-1:0]   dpaddr_o,
    output logic                ifault_o,
    output logic                dfault_o,
    output mem_pkg::mmu2dmem_s  dmem_req_o,
    input  mem_pkg::dmem2mmu_s  dmem_rsp_i
);

    mmu_pkg::mmu2ptw_s                      mmu2ptw;
    mmu_pkg::ptw2mmu_s                      ptw2mmu;
    mmu_pkg::ptw2tlb_s                      ptw2tlb;
    mmu_pkg::tlb_lookup_s [`TLB_PORTS-1:0]  tlb_lookup;
    logic [`TLB_PORTS-1:0]                  tlb_update;
    logic [`TLB_PORTS-1:0][19:0]            lookup_vpn;

    assign lookup_vpn[0] = ivaddr_i[31:12];
    assign lookup_vpn[1] = dvaddr_i[31:12];

    ptw u_ptw (
        .clk          (clk),
        .rst_n        (rst_n),
        .mmu2ptw_i    (mmu2ptw),
        .ptw2mmu_o    (ptw2mmu),
        .ptw2tlb_o    (ptw2tlb),
        .tlb_update_o (tlb_update),
        .ptw2dmem_o   (dmem_req_o),
        .dmem2ptw_i   (dmem_rsp_i)
    );

    for (genvar p = 0; p < `TLB_PORTS; p++) begin : g_tlb
        tlb u_tlb (
            .clk          (clk),
            .rst_n        (rst_n),
            .lookup_vpn_i (lookup_vpn[p]),
            .update_i     (tlb_update[p]),
            .ptw2tlb_i    (ptw2tlb),
            .flush_i      (flush_i),
            .lookup_o     (tlb_lookup[p])
        );
    end

    mmu_xlate u_xlate (
        .ireq_i     (ireq_i),
        .ivaddr_i   (ivaddr_i),
        .dreq_i     (dreq_i),
        .dvaddr_i   (dvaddr_i),
        .is_store_i (is_store_i),
        .mxr_i      (mxr_i),
        .satp_ppn_i (satp_ppn_i),
        .flush_i    (flush_i),
        .lookup_i   (tlb_lookup),
        .ptw2mmu_i  (ptw2mmu),
        .mmu2ptw_o  (mmu2ptw),
        .ivalid_o   (ivalid_o),
        .ipaddr_o   (ipaddr_o),
        .dvalid_o   (dvalid_o),
        .dpaddr_o   (dpaddr_o),
        .ifault_o   (ifault_o),
        .dfault_o   (dfault_o)
    );

endmodule

/* mmu_assertions.sv */
`timescale 1ns/1ns
`include "mmu_macros.svh"

module mmu_assertions (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  ireq_i,
    input logic [`VALEN-1:0]     ivaddr_i,
    input logic                  dreq_i,
    input logic [`VALEN-1:0]     dvaddr_i,
    input logic                  is_store_i,
    input logic                  mxr_i,
    input logic                  flush_i,
    input logic                  ivalid_i,
    input logic [`PALEN-1:0]     ipaddr_i,
    input logic                  dvalid_i,
    input logic [`PALEN-1:0]     dpaddr_i,
    input logic                  ifault_i,
    input logic                  dfault_i,
    input mmu_pkg::ptw2mmu_s     ptw2mmu_i,
    input logic [`TLB_PORTS-1:0] tlb_update_i,
    input mem_pkg::mmu2dmem_s    dmem_req_i,
    input mem_pkg::dmem2mmu_s    dmem_rsp_i
);

    // Page table layout held by the testbench memory
    localparam logic [21:0] LIN_OFF    = 22'h02000;
    localparam logic [11:0] SUPER_PPN1 = 12'h040;

    int                    err_cnt = 0;
    logic                  rd_pending;
    logic                  walk_killed;
    logic [`TLB_PORTS-1:0] stale;

    // Superpage region B keeps VPN[0], the linear pages add a fixed PPN offset
    function automatic logic [`PALEN-1:0] exp_paddr(input logic [`VALEN-1:0] va);
        if (va[31:22] == 10'd1)
            return {SUPER_PPN1, va[21:0]};
        else
            return {{2'b00, va[31:12]} + LIN_OFF, va[11:0]};
    endfunction

    // Misaligned superpage, invalid PTE, and the clean page which has no X
    function automatic logic fetch_faults(input logic [`VALEN-1:0] va);
        return (va[31:22] == 10'd2) || (va[31:12] == 20'h0010A) ||
               (va[31:12] == 20'h00109);
    endfunction

    function automatic logic data_faults(
        input logic [`VALEN-1:0] va,
        input logic              st,
        input logic              mx
    );
        logic x_only;
        x_only = (va[31:12] == 20'h00108);
        return (va[31:22] == 10'd2) || (va[31:12] == 20'h0010A) ||
               ((va[31:12] == 20'h00109) && st) || (x_only && (st || !mx));
    endfunction

    // One read in flight at a time
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            rd_pending <= 1'b0;
        else if (dmem_req_i.r_req)
            rd_pending <= 1'b1;
        else if (dmem_rsp_i.r_valid)
            rd_pending <= 1'b0;
    end

    // A walk cut by a flush lasts until the walker is idle again
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            walk_killed <= 1'b0;
        else if (flush_i && ptw2mmu_i.ptw_active)
            walk_killed <= 1'b1;
        else if (!ptw2mmu_i.ptw_active)
            walk_killed <= 1'b0;
    end

    // Empty TLB side, only a new walk may refill it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stale <= '1;
        end else begin
            for (int k = 0; k < `TLB_PORTS; k++) begin
                if (flush_i)
                    stale[k] <= 1'b1;
                else if (tlb_update_i[k])
                    stale[k] <= 1'b0;
            end
        end
    end

    a_ipaddr: assert property (@(posedge clk) disable iff (!rst_n)
        ivalid_i |-> (ipaddr_i == exp_paddr(ivaddr_i)) && !fetch_faults(ivaddr_i))
        else begin
            err_cnt++;
            $error("[ERROR] %0t ns: fetch of %h translated to %h", $time, ivaddr_i, ipaddr_i);
        end

    a_dpaddr: assert property (@(posedge clk) disable iff (!rst_n)
        dvalid_i |-> (dpaddr_i == exp_paddr(dvaddr_i)) &&
                     !data_faults(dvaddr_i, is_store_i, mxr_i))
        else begin
            err_cnt++;
            $error("[ERROR] %0t ns: access to %h translated to %h", $time, dvaddr_i, dpaddr_i);
        end

    a_ifault: assert property (@(posedge clk) disable iff (!rst_n)
        ifault_i |-> ireq_i && fetch_faults(ivaddr_i))
        else begin
            err_cnt++;
            $error("[ERROR] %0t ns: unexpected fetch fault at %h", $time, ivaddr_i);
        end

    a_dfault: assert property (@(posedge clk) disable iff (!rst_n)
        dfault_i |-> dreq_i && data_faults(dvaddr_i, is_store_i, mxr_i))
        else begin
            err_cnt++;
            $error("[ERROR] %0t ns: unexpected data fault at %h", $time, dvaddr_i);
        end

    a_fault_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        (ifault_i || dfault_i) |=> !(ifault_i || dfault_i))
        else begin
            err_cnt++;
            $error("[ERROR] %0t ns: fault held longer than one cycle", $time);
        end

    a_fetch_first: assert property (@(posedge clk) disable iff (!rst_n)
        ireq_i && !ivalid_i && !ptw2mmu_i.ptw_active && !flush_i |=> ptw2mmu_i.iwalk_active)
        else begin
            err_cnt++;
            $error("[ERROR] %0t ns: fetch miss did not start the walk", $time);
        end

    a_one_read: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req_i.r_req |-> !rd_pending)
        else begin
            err_cnt++;
            $error("[ERROR] %0t ns: read issued while another is outstanding", $time);
        end

    a_flush_update: assert property (@(posedge clk) disable iff (!rst_n)
        (flush_i || walk_killed) |-> (tlb_update_i == '0))
        else begin
            err_cnt++;
            $error("[ERROR] %0t ns: TLB written by a flushed walk", $time);
        end

    a_refill: assert property (@(posedge clk) disable iff (!rst_n)
        !((ivalid_i && stale[0]) || (dvalid_i && stale[1])))
        else begin
            err_cnt++;
            $error("[ERROR] %0t ns: hit without a walk after flush or reset", $time);
        end

endmodule

/* tb_mmu.sv */
`timescale 1ns/1ns
`include "mmu_macros.svh"

module tb_mmu;

    localparam int          CYCLE_LIMIT = 2000;
    localparam logic [21:0] ROOT_PPN    = 22'h00010;
    localparam logic [21:0] L2_PPN      = 22'h00011;
    localparam logic [21:0] LIN_OFF     = 22'h02000;
    localparam logic [11:0] SUPER_PPN1  = 12'h040;

    logic                clk;
    logic                rst_n;
    logic                ireq;
    logic [`VALEN-1:0]   ivaddr;
    logic                dreq;
    logic [`VALEN-1:0]   dvaddr;
    logic                is_store;
    logic                mxr;
    logic [21:0]         satp_ppn;
    logic                flush;
    logic                ivalid;
    logic [`PALEN-1:0]   ipaddr;
    logic                dvalid;
    logic [`PALEN-1:0]   dpaddr;
    logic                ifault;
    logic                dfault;
    mem_pkg::mmu2dmem_s  dmem_req;
    mem_pkg::dmem2mmu_s  dmem_rsp = '0;

    // Root table at word 0 and second level table at word 1024
    logic [`XLEN-1:0]    pt_mem [2048];
    logic [1:0]          rd_pipe = '0;
    logic [10:0]         idx_pipe [2];
    int                  cycles = 0;
    int                  seed = 37930;
    int                  errors;

    mmu_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .ireq_i     (ireq),
        .ivaddr_i   (ivaddr),
        .dreq_i     (dreq),
        .dvaddr_i   (dvaddr),
        .is_store_i (is_store),
        .mxr_i      (mxr),
        .satp_ppn_i (satp_ppn),
        .flush_i    (flush),
        .ivalid_o   (ivalid),
        .ipaddr_o   (ipaddr),
        .dvalid_o   (dvalid),
        .dpaddr_o   (dpaddr),
        .ifault_o   (ifault),
        .dfault_o   (dfault),
        .dmem_req_o (dmem_req),
        .dmem_rsp_i (dmem_rsp)
    );

    bind mmu_top mmu_assertions u_asrt (
        .clk          (clk),
        .rst_n        (rst_n),
        .ireq_i       (ireq_i),
        .ivaddr_i     (ivaddr_i),
        .dreq_i       (dreq_i),
        .dvaddr_i     (dvaddr_i),
        .is_store_i   (is_store_i),
        .mxr_i        (mxr_i),
        .flush_i      (flush_i),
        .ivalid_i     (ivalid_o),
        .ipaddr_i     (ipaddr_o),
        .dvalid_i     (dvalid_o),
        .dpaddr_i     (dpaddr_o),
        .ifault_i     (ifault_o),
        .dfault_i     (dfault_o),
        .ptw2mmu_i    (ptw2mmu),
        .tlb_update_i (tlb_update),
        .dmem_req_i   (dmem_req_o),
        .dmem_rsp_i   (dmem_rsp_i)
    );

    always #20 clk = ~clk;

    // Each read strobe is answered three cycles later
    always @(posedge clk) begin
        rd_pipe          <= {rd_pipe[0], dmem_req.r_req & rst_n};
        idx_pipe[0]      <= dmem_req.paddr[12:2];
        idx_pipe[1]      <= idx_pipe[0];
        dmem_rsp.r_valid <= rd_pipe[1];
        dmem_rsp.r_data  <= pt_mem[idx_pipe[1]];
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: translations did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic [`VALEN-1:0] page_va(input logic [19:0] vpn);
        return {vpn, 12'($random(seed))};
    endfunction

    task automatic fetch(input logic [`VALEN-1:0] va);
        @(posedge clk);
        ireq   <= 1'b1;
        ivaddr <= va;
        do @(posedge clk); while (!(ivalid || ifault));
        ireq <= 1'b0;
    endtask

    task automatic access_data(input logic [`VALEN-1:0] va, input logic st, input logic mx);
        @(posedge clk);
        dreq     <= 1'b1;
        dvaddr   <= va;
        is_store <= st;
        mxr      <= mx;
        do @(posedge clk); while (!(dvalid || dfault));
        dreq     <= 1'b0;
        is_store <= 1'b0;
        mxr      <= 1'b0;
    endtask

    // Both sides miss together and fetch has to go first
    task automatic fetch_and_load(input logic [`VALEN-1:0] iva, input logic [`VALEN-1:0] dva);
        @(posedge clk);
        ireq   <= 1'b1;
        ivaddr <= iva;
        dreq   <= 1'b1;
        dvaddr <= dva;
        do @(posedge clk); while (!(ivalid || ifault));
        ireq <= 1'b0;
        do @(posedge clk); while (!(dvalid || dfault));
        dreq <= 1'b0;
    endtask

    task automatic flush_mid_walk(input logic [`VALEN-1:0] va);
        @(posedge clk);
        ireq   <= 1'b1;
        ivaddr <= va;
        do @(posedge clk); while (!dmem_req.r_req);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        // Fetch stays up while the cut walk drains its read and walks again
        do @(posedge clk); while (!(ivalid || ifault));
        ireq <= 1'b0;
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        ireq     = 1'b0;
        ivaddr   = '0;
        dreq     = 1'b0;
        dvaddr   = '0;
        is_store = 1'b0;
        mxr      = 1'b0;
        satp_ppn = ROOT_PPN;
        flush    = 1'b0;

        for (int i = 0; i < 2048; i++)
            pt_mem[11'(i)] = {11'(i), 21'h0};
        pt_mem[11'd0] = {L2_PPN, 2'b00, 8'h01};
        pt_mem[11'd1] = {SUPER_PPN1, 10'h000, 2'b00, 8'hCF};
        pt_mem[11'd2] = {12'h041, 10'h005, 2'b00, 8'hCF};
        for (int k = 0; k < 8; k++)
            pt_mem[11'(1280 + k)] = {22'(256 + k) + LIN_OFF, 2'b00, 8'hCF};
        pt_mem[11'd1288] = {22'd264 + LIN_OFF, 2'b00, 8'h49};
        pt_mem[11'd1289] = {22'd265 + LIN_OFF, 2'b00, 8'h47};
        pt_mem[11'd1290] = {22'd266 + LIN_OFF, 2'b00, 8'h4E};

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // Walk and then hit on the same page
        fetch(page_va(20'h00100 + 20'($random(seed) & 3)));
        fetch({ivaddr[31:12], 12'($random(seed))});
        access_data(page_va({10'h001, 10'($random(seed))}), 1'b0, 1'b0);

        fetch(page_va(20'h00833));
        access_data(page_va(20'h0010A), 1'b0, 1'b0);
        access_data(page_va(20'h00109), 1'b1, 1'b0);

        fetch_and_load(page_va(20'h00106), page_va(20'h00107));
        access_data(page_va(20'h00108), 1'b0, 1'b0);
        access_data(page_va(20'h00108), 1'b0, 1'b1);

        flush_mid_walk(page_va(20'h00105));
        access_data(page_va({10'h001, 10'($random(seed))}), 1'b0, 1'b0);

        repeat (2) @(posedge clk);
        errors = dut.u_asrt.err_cnt;
        $display("Run finished after %0d cycles with %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+.
mmu_pkg.sv
mem_pkg.sv
ptw.sv
tlb.sv
mmu_xlate.sv
mmu_top.sv
mmu_assertions.sv
tb_mmu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mmu
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "^Result: PASSED$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
